//--- rtl/bank_geom_pkg.sv
// ========================================
// Bank geometry
// Sizes of the banked scratchpad plus the index, address
// and swizzle configuration types built from them
// ========================================
package bank_geom_pkg;

	// Base geometry
	localparam int NBANK  = 16;
	localparam int NDATA  = 32;
	localparam int BW     = 8;
	// Row bits that a swizzle scheme may pick from
	localparam int XOR_BW = 4;

	// Derived widths
	localparam int LG_NBANK = $clog2(NBANK);
	localparam int LG_NDATA = $clog2(NDATA);
	// Lane address, row bits sit above bank bits
	localparam int ABW      = LG_NDATA + LG_NBANK;
	localparam int SCH_W    = $clog2(XOR_BW);
	// Rotation runs 0..LG_NBANK, one stage per bit
	localparam int ROT_W    = $clog2(LG_NBANK + 1);

	typedef logic [LG_NBANK-1:0] bank_idx_t;
	typedef logic [LG_NDATA-1:0] row_t;
	typedef logic [ABW-1:0]      lane_addr_t;
	typedef logic [BW-1:0]       word_t;
	typedef logic [SCH_W-1:0]    scheme_t;
	typedef logic [ROT_W-1:0]    rot_t;

	// Swizzle setup carried with every request
	typedef struct packed {
		bank_idx_t                  xor_mask;
		scheme_t [LG_NBANK-1:0]     scheme;
		rot_t                       rot;
	} swz_cfg_t;

endpackage

//--- rtl/bank_xfer_pkg.sv
// ========================================
// Bank transfer records
// Request, stage and response payloads passed between
// the read pipeline stages and the bank array
// ========================================
package bank_xfer_pkg;

	// Vector read request, one address per lane
	typedef struct packed {
		bank_geom_pkg::lane_addr_t [bank_geom_pkg::NBANK-1:0] addr;
		bank_geom_pkg::swz_cfg_t                             cfg;
		// Tag goes back to the pool once this one is consumed
		logic                                                retire;
	} rd_req_t;

	// Stage 1 holds what the return path needs
	typedef struct packed {
		// Physical bank of every lane, steers the un-butterfly
		bank_geom_pkg::bank_idx_t [bank_geom_pkg::NBANK-1:0] bank;
		bank_geom_pkg::rot_t                                rot;
		logic                                               retire;
	} rd_s1_t;

	// Response, data already in lane order
	typedef struct packed {
		bank_geom_pkg::word_t [bank_geom_pkg::NBANK-1:0] data;
		logic                                           retire;
	} rd_rsp_t;

	// Read command to the bank array
	typedef struct packed {
		logic [bank_geom_pkg::NBANK-1:0]              re;
		bank_geom_pkg::row_t [bank_geom_pkg::NBANK-1:0] row;
	} sram_rd_t;

endpackage

//--- rtl/rdyack_fwd.sv
// ========================================
// Ready/ack forward register
// One slot pipeline stage for any payload type
// ========================================
`timescale 1ns/100ps

module rdyack_fwd #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst,
	// Upstream side
	input  logic i_src_rdy,
	output logic o_src_ack,
	input  T     i_src,
	// Downstream side
	output logic o_dst_rdy,
	input  logic i_dst_ack,
	output T     o_dst
);

	logic full_r;
	T     data_r;

	// Take new data when empty or when the held word leaves now
	assign o_src_ack = i_src_rdy && (!full_r || i_dst_ack);
	assign o_dst_rdy = full_r;
	assign o_dst     = data_r;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full_r <= 1'b0;
		end else if (o_src_ack) begin
			full_r <= 1'b1;
		end else if (full_r && i_dst_ack) begin
			full_r <= 1'b0;
		end
	end

	// Payload only moves on a source handshake
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			data_r <= i_src;
		end
	end

	// Offered data must not change until it is taken
	a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dst_rdy && !i_dst_ack |=> $stable(o_dst))
		else $error("rdyack_fwd payload changed while waiting for ack");

endmodule

//--- rtl/read_tag_pool.sv
// ========================================
// Read tag pool
// Free list of read tags, hands out the lowest free tag
// and takes tags back from retiring responses
// ========================================
`timescale 1ns/100ps

module read_tag_pool #(
	parameter int  N_TAG = 4,
	localparam int TAG_W = $clog2(N_TAG)
) (
	input  logic             i_clk,
	input  logic             i_rst,
	// Allocation, i_take is the request handshake
	input  logic             i_take,
	output logic             o_avail,
	output logic [TAG_W-1:0] o_tag,
	// Reclaim from a consumed retiring response
	input  logic             i_free,
	input  logic [TAG_W-1:0] i_free_tag
);

	// One bit per tag, set means free
	logic [N_TAG-1:0] free_r;

	assign o_avail = |free_r;

	// Lowest free tag wins
	always_comb begin
		o_tag = '0;
		for (int t = N_TAG - 1; t >= 0; t--) begin
			if (free_r[t]) begin
				o_tag = TAG_W'(t);
			end
		end
	end

	// Take and free never touch the same tag in one cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			free_r <= '1;
		end else begin
			if (i_take) begin
				free_r[o_tag] <= 1'b0;
			end
			if (i_free) begin
				free_r[i_free_tag] <= 1'b1;
			end
		end
	end

	//========================================
	// Checks
	//========================================
	// A tag comes back only once per allocation
	a_no_double_free: assert property (@(posedge i_clk) disable iff (i_rst)
		i_free |-> !free_r[i_free_tag])
		else $error("tag %0d freed while already free", i_free_tag);

	// Upstream must wait for o_avail before taking
	a_no_take_empty: assert property (@(posedge i_clk) disable iff (i_rst)
		i_take |-> o_avail)
		else $error("tag taken from an empty pool");

endmodule

//--- rtl/bank_sram_array.sv
// ========================================
// Bank array
// NBANK single port banks with registered read data
// and a one word per cycle preload port
// ========================================
`timescale 1ns/100ps

module bank_sram_array (
	input  logic                                             i_clk,
	input  logic                                             i_rst,
	// Read command from the read interface
	input  bank_xfer_pkg::sram_rd_t                          i_rd,
	output bank_geom_pkg::word_t [bank_geom_pkg::NBANK-1:0]  o_rdata,
	// Preload
	input  logic                                             i_wr_en,
	input  bank_geom_pkg::bank_idx_t                         i_wr_bank,
	input  bank_geom_pkg::row_t                              i_wr_row,
	input  bank_geom_pkg::word_t                             i_wr_data
);

	import bank_geom_pkg::*;
	import bank_xfer_pkg::*;

	//========================================
	// Banks
	//========================================
	for (genvar b = 0; b < NBANK; b++) begin : g_bank
		word_t mem_r [NDATA];
		word_t rdata_r;

		// Preload lands in the addressed bank only
		always_ff @(posedge i_clk) begin
			if (i_wr_en && i_wr_bank == bank_idx_t'(b)) begin
				mem_r[i_wr_row] <= i_wr_data;
			end
		end

		// Output register keeps its word until the next read of this bank
		always_ff @(posedge i_clk) begin
			if (i_rst) begin
				rdata_r <= '0;
			end else if (i_rd.re[b]) begin
				rdata_r <= mem_r[i_rd.row[b]];
			end
		end

		assign o_rdata[b] = rdata_r;
	end

	// A stalled stage 1 still reads this data, so no bank
	// may be both read and preloaded at the same row
	a_no_rw_clash: assert property (@(posedge i_clk) disable iff (i_rst)
		i_wr_en |-> !(i_rd.re[i_wr_bank] && i_rd.row[i_wr_bank] == i_wr_row))
		else $error("preload collides with a read of bank %0d", i_wr_bank);

endmodule

//--- rtl/bank_sram_read_if.sv
// ========================================
// Bank read interface
// Swizzles lane addresses onto banks, routes rows through
// a butterfly and returns data in lane order, optionally
// rotated, through two forward stages
// ========================================
`timescale 1ns/100ps

module bank_sram_read_if #(
	parameter int  N_TAG = 4,
	localparam int TAG_W = $clog2(N_TAG)
) (
	input  logic                                            i_clk,
	input  logic                                            i_rst,
	// Request
	input  logic                                            i_req_rdy,
	output logic                                            o_req_ack,
	input  bank_xfer_pkg::rd_req_t                          i_req,
	input  logic [TAG_W-1:0]                                i_tag,
	input  logic                                            i_tag_avail,
	// Bank array
	output bank_xfer_pkg::sram_rd_t                         o_sram,
	input  bank_geom_pkg::word_t [bank_geom_pkg::NBANK-1:0] i_sram_rdata,
	// Response
	output logic                                            o_rsp_rdy,
	input  logic                                            i_rsp_ack,
	output bank_xfer_pkg::rd_rsp_t                          o_rsp,
	output logic [TAG_W-1:0]                                o_rsp_tag,
	// Tag return
	output logic                                            o_free,
	output logic [TAG_W-1:0]                                o_free_tag
);

	import bank_geom_pkg::*;
	import bank_xfer_pkg::*;

	// Rotation by LG_NBANK wraps to identity, so only these rotate stages do work
	localparam int ROT_ST = $clog2(LG_NBANK);
	// Return data passes LG_NBANK butterfly levels and then the rotate stages
	localparam int DAT_LV = LG_NBANK + ROT_ST + 1;

	// Tags ride along with each stage payload
	typedef struct packed {
		rd_s1_t             info;
		logic [TAG_W-1:0]   tag;
	} s1_pay_t;

	typedef struct packed {
		rd_rsp_t            rsp;
		logic [TAG_W-1:0]   tag;
	} s2_pay_t;

	//========================================
	// Internal
	//========================================
	bank_idx_t [NBANK-1:0] pick_w;
	bank_idx_t [NBANK-1:0] bank_w;
	logic                  routable_w;
	row_t [NBANK-1:0]      row_lv [LG_NBANK+1];
	logic [NBANK-1:0]      ren_lv [LG_NBANK+1];
	word_t [NBANK-1:0]     dat_lv [DAT_LV];
	s1_pay_t               s1_in_w;
	s1_pay_t               s1_w;
	logic                  s1_rdy;
	logic                  s1_ack;
	s2_pay_t               s2_in_w;
	s2_pay_t               s2_w;

	//========================================
	// Swizzle
	//========================================
	// Bank = low bits XOR (mask AND row bits picked per bank bit)
	always_comb begin
		for (int j = 0; j < NBANK; j++) begin
			for (int b = 0; b < LG_NBANK; b++) begin
				pick_w[j][b] = i_req.addr[j][LG_NBANK + i_req.cfg.scheme[b]];
			end
			bank_w[j] = i_req.addr[j][LG_NBANK-1:0] ^ (i_req.cfg.xor_mask & pick_w[j]);
		end
	end

	// Routable when every lane lands on lane XOR one constant
	always_comb begin
		routable_w = 1'b1;
		for (int j = 1; j < NBANK; j++) begin
			if ((bank_w[j] ^ bank_idx_t'(j)) != bank_w[0]) begin
				routable_w = 1'b0;
			end
		end
	end

	//========================================
	// Address butterfly
	//========================================
	// Top level holds rows in lane order and level 0 in bank order
	always_comb begin
		int   mate;
		logic side;
		logic own_sel;
		logic mate_sel;
		for (int j = 0; j < NBANK; j++) begin
			row_lv[LG_NBANK][j] = i_req.addr[j][ABW-1 -: LG_NDATA];
		end
		ren_lv[LG_NBANK] = '1;
		for (int lv = LG_NBANK - 1; lv >= 0; lv--) begin
			for (int j = 0; j < NBANK; j++) begin
				mate     = j ^ (1 << lv);
				side     = ((j >> lv) & 1) != 0;
				// Exactly one of the pair heads to this side
				own_sel  = bank_w[j][lv] == side;
				mate_sel = bank_w[mate][lv] == side;
				ren_lv[lv][j] = (own_sel && ren_lv[lv+1][j]) ||
					(mate_sel && ren_lv[lv+1][mate]);
				row_lv[lv][j] = (own_sel ? row_lv[lv+1][j] : '0) |
					(mate_sel ? row_lv[lv+1][mate] : '0);
			end
		end
	end

	// Banks read only in the acceptance cycle
	assign o_sram.re  = o_req_ack ? ren_lv[0] : '0;
	assign o_sram.row = row_lv[0];

	//========================================
	// Stage 1
	//========================================
	assign s1_in_w.info.bank   = bank_w;
	assign s1_in_w.info.rot    = i_req.cfg.rot;
	assign s1_in_w.info.retire = i_req.retire;
	assign s1_in_w.tag         = i_tag;

	// Acceptance waits for a free tag
	rdyack_fwd #(.T(s1_pay_t)) u_fwd_s1 (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (i_req_rdy && i_tag_avail),
		.o_src_ack (o_req_ack),
		.i_src     (s1_in_w),
		.o_dst_rdy (s1_rdy),
		.i_dst_ack (s1_ack),
		.o_dst     (s1_w)
	);

	//========================================
	// Return path
	//========================================
	always_comb begin
		int mate;
		int sh;
		int src;
		dat_lv[0] = i_sram_rdata;
		// Undo the butterfly steered by the held bank indices
		for (int lv = 0; lv < LG_NBANK; lv++) begin
			for (int j = 0; j < NBANK; j++) begin
				mate = j ^ (1 << lv);
				if (s1_w.info.bank[j][lv] == (((j >> lv) & 1) != 0)) begin
					dat_lv[lv+1][j] = dat_lv[lv][j];
				end else begin
					dat_lv[lv+1][j] = dat_lv[lv][mate];
				end
			end
		end
		// Lane j takes lane rotl(j, rot) with one power of two per stage
		for (int r = 0; r < ROT_ST; r++) begin
			sh = 1 << r;
			for (int j = 0; j < NBANK; j++) begin
				src = ((j << sh) | (j >> (LG_NBANK - sh))) & (NBANK - 1);
				if (s1_w.info.rot[r]) begin
					dat_lv[LG_NBANK+r+1][j] = dat_lv[LG_NBANK+r][src];
				end else begin
					dat_lv[LG_NBANK+r+1][j] = dat_lv[LG_NBANK+r][j];
				end
			end
		end
	end

	//========================================
	// Stage 2
	//========================================
	assign s2_in_w.rsp.data   = dat_lv[DAT_LV-1];
	assign s2_in_w.rsp.retire = s1_w.info.retire;
	assign s2_in_w.tag        = s1_w.tag;

	rdyack_fwd #(.T(s2_pay_t)) u_fwd_s2 (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_src_rdy (s1_rdy),
		.o_src_ack (s1_ack),
		.i_src     (s2_in_w),
		.o_dst_rdy (o_rsp_rdy),
		.i_dst_ack (i_rsp_ack),
		.o_dst     (s2_w)
	);

	assign o_rsp     = s2_w.rsp;
	assign o_rsp_tag = s2_w.tag;

	// A consumed retiring response hands its tag back
	assign o_free     = o_rsp_rdy && i_rsp_ack && s2_w.rsp.retire;
	assign o_free_tag = s2_w.tag;

	// Conflict-free only when all lanes share one lane-XOR-bank value
	a_routable: assert property (@(posedge i_clk) disable iff (i_rst)
		o_req_ack |-> routable_w)
		else $error("accepted request is not routable through the butterfly");

endmodule

//--- rtl/banked_read_top.sv
// ========================================
// Banked read top
// Tag pool, read interface and bank array of the
// scratchpad read side
// ========================================
`timescale 1ns/100ps

module banked_read_top #(
	parameter int  N_TAG = 4,
	localparam int TAG_W = $clog2(N_TAG)
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	// Request
	input  logic                      i_req_rdy,
	output logic                      o_req_ack,
	input  bank_xfer_pkg::rd_req_t    i_req,
	// Response
	output logic                      o_rsp_rdy,
	input  logic                      i_rsp_ack,
	output bank_xfer_pkg::rd_rsp_t    o_rsp,
	output logic [TAG_W-1:0]          o_rsp_tag,
	// Preload
	input  logic                      i_wr_en,
	input  bank_geom_pkg::bank_idx_t  i_wr_bank,
	input  bank_geom_pkg::row_t       i_wr_row,
	input  bank_geom_pkg::word_t      i_wr_data
);

	import bank_geom_pkg::*;
	import bank_xfer_pkg::*;

	logic              tag_avail;
	logic [TAG_W-1:0]  tag;
	logic              free;
	logic [TAG_W-1:0]  free_tag;
	sram_rd_t          sram_rd;
	word_t [NBANK-1:0] sram_rdata;

	// A tag leaves the pool on every request handshake
	read_tag_pool #(.N_TAG(N_TAG)) u_tag_pool (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_take     (o_req_ack),
		.o_avail    (tag_avail),
		.o_tag      (tag),
		.i_free     (free),
		.i_free_tag (free_tag)
	);

	bank_sram_read_if #(.N_TAG(N_TAG)) u_read_if (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_req_rdy    (i_req_rdy),
		.o_req_ack    (o_req_ack),
		.i_req        (i_req),
		.i_tag        (tag),
		.i_tag_avail  (tag_avail),
		.o_sram       (sram_rd),
		.i_sram_rdata (sram_rdata),
		.o_rsp_rdy    (o_rsp_rdy),
		.i_rsp_ack    (i_rsp_ack),
		.o_rsp        (o_rsp),
		.o_rsp_tag    (o_rsp_tag),
		.o_free       (free),
		.o_free_tag   (free_tag)
	);

	bank_sram_array u_bank_array (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_rd      (sram_rd),
		.o_rdata   (sram_rdata),
		.i_wr_en   (i_wr_en),
		.i_wr_bank (i_wr_bank),
		.i_wr_row  (i_wr_row),
		.i_wr_data (i_wr_data)
	);

endmodule

//--- verification/tb_clk_gen.sv
// ========================================
// Testbench clock and reset
// Free running clock plus a synchronous reset pulse
// ========================================
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 10
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// Reset drops just after the last reset edge, like any other input
	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		#2;
		o_rst = 1'b0;
	end

endmodule

//--- verification/tb_banked_read.sv
// ========================================
// Banked read testbench
// Preloads the banks, sends swizzled and rotated vector
// reads and checks data, order and tags against a model
// ========================================
`timescale 1ns/100ps

module tb_banked_read;

	import bank_geom_pkg::*;
	import bank_xfer_pkg::*;

	localparam int N_TAG       = 4;
	localparam int TAG_W       = $clog2(N_TAG);
	localparam int CLK_NS      = 40;
	localparam int SEED        = 66;
	// Requests per test
	localparam int N_ID        = 8;
	localparam int N_SWZ       = 24;
	localparam int N_ROT_EACH  = 3;
	localparam int N_BP        = 32;
	localparam int N_STALL_CYC = 20;
	localparam int TOTAL_REQ   = N_ID + N_SWZ + N_ROT_EACH * LG_NBANK + N_BP + 2 * N_TAG + 3;
	localparam longint WATCHDOG_NS = longint'(TOTAL_REQ) * 40 * CLK_NS +
		longint'(NBANK * NDATA + 30) * CLK_NS;
	// Response ack modes
	localparam int ACK_HIGH    = 0;
	localparam int ACK_PATTERN = 1;
	localparam int ACK_PAT_LEN = 256;

	logic             clk;
	logic             rst;
	logic             req_rdy;
	logic             req_ack;
	rd_req_t          req;
	logic             rsp_rdy;
	logic             rsp_ack;
	rd_rsp_t          rsp;
	logic [TAG_W-1:0] rsp_tag;
	logic             wr_en;
	bank_idx_t        wr_bank;
	row_t             wr_row;
	word_t            wr_data;

	//========================================
	// Scoreboard state
	//========================================
	rd_rsp_t          exp_q [$];
	logic [TAG_W-1:0] tag_q [$];
	// Model of the tag pool where a set bit means free
	logic [N_TAG-1:0] free_model = '1;
	rd_rsp_t          held_rsp;
	logic [TAG_W-1:0] held_tag;
	logic             held_valid = 1'b0;
	int               err_cnt = 0;
	int               acc_cnt = 0;
	int               rsp_cnt = 0;
	int               tag_stall_cnt = 0;
	int               pass_cnt = 0;
	int               fail_cnt = 0;
	int               err_mark;
	int               acc_mark;
	int               rsp_mark;
	int               ack_mode = ACK_HIGH;
	logic [ACK_PAT_LEN-1:0] ack_pat;

	tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(10)) u_clk_gen (
		.o_clk (clk),
		.o_rst (rst)
	);

	banked_read_top #(.N_TAG(N_TAG)) banked_read_top_i (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_req_rdy (req_rdy),
		.o_req_ack (req_ack),
		.i_req     (req),
		.o_rsp_rdy (rsp_rdy),
		.i_rsp_ack (rsp_ack),
		.o_rsp     (rsp),
		.o_rsp_tag (rsp_tag),
		.i_wr_en   (wr_en),
		.i_wr_bank (wr_bank),
		.i_wr_row  (wr_row),
		.i_wr_data (wr_data)
	);

	//========================================
	// Model
	//========================================
	// Preload contents mix every bank and row bit
	function automatic word_t fill_word(input bank_idx_t bank, input row_t row);
		return word_t'((int'(bank) << 4) ^ (int'(row) * 29) ^ int'(bank) ^ 'h5a);
	endfunction

	// Lane index rotated left inside LG_NBANK bits
	function automatic int rotl_idx(input int idx, input int amt);
		bank_idx_t v;
		v = bank_idx_t'(idx);
		for (int k = 0; k < amt; k++) begin
			v = {v[LG_NBANK-2:0], v[LG_NBANK-1]};
		end
		return int'(v);
	endfunction

	// Expected response of one request
	function automatic rd_rsp_t ref_read(input rd_req_t r);
		rd_rsp_t   res;
		word_t     pre [NBANK];
		bank_idx_t hi;
		bank_idx_t bank;
		for (int j = 0; j < NBANK; j++) begin
			// Scheme b picks address bit LG_NBANK + scheme for bank bit b
			for (int b = 0; b < LG_NBANK; b++) begin
				hi[b] = r.addr[j][LG_NBANK + int'(r.cfg.scheme[b])];
			end
			bank   = r.addr[j][LG_NBANK-1:0] ^ (r.cfg.xor_mask & hi);
			pre[j] = fill_word(bank, r.addr[j][ABW-1:LG_NBANK]);
		end
		for (int j = 0; j < NBANK; j++) begin
			res.data[j] = pre[rotl_idx(j, int'(r.cfg.rot))];
		end
		res.retire = r.retire;
		return res;
	endfunction

	function automatic int lowest_free(input logic [N_TAG-1:0] v);
		for (int t = 0; t < N_TAG; t++) begin
			if (v[t]) begin
				return t;
			end
		end
		return -1;
	endfunction

	//========================================
	// Stimulus helpers
	//========================================
	function automatic swz_cfg_t rand_cfg(input int rot);
		swz_cfg_t cfg;
		cfg.xor_mask = bank_idx_t'($urandom);
		for (int b = 0; b < LG_NBANK; b++) begin
			cfg.scheme[b] = scheme_t'($urandom_range(XOR_BW - 1));
		end
		cfg.rot = rot_t'(rot);
		return cfg;
	endfunction

	// Random rows with low bits chosen so lane j lands on bank j ^ c
	function automatic rd_req_t make_req(input bank_idx_t c, input swz_cfg_t cfg,
		input logic retire);
		rd_req_t   r;
		row_t      row;
		bank_idx_t hi;
		r.cfg    = cfg;
		r.retire = retire;
		for (int j = 0; j < NBANK; j++) begin
			row = row_t'($urandom_range(NDATA - 1));
			for (int b = 0; b < LG_NBANK; b++) begin
				hi[b] = row[cfg.scheme[b]];
			end
			r.addr[j] = {row, bank_idx_t'(j) ^ c ^ (cfg.xor_mask & hi)};
		end
		return r;
	endfunction

	task automatic log_error(input string msg);
		err_cnt++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic log_mismatch(input string msg);
		err_cnt++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	task automatic preload_all();
		for (int b = 0; b < NBANK; b++) begin
			for (int r = 0; r < NDATA; r++) begin
				wr_en   = 1'b1;
				wr_bank = bank_idx_t'(b);
				wr_row  = row_t'(r);
				wr_data = fill_word(bank_idx_t'(b), row_t'(r));
				@(posedge clk);
				#2;
			end
		end
		wr_en = 1'b0;
	endtask

	// Holds the request until the DUT acks it
	task automatic send_req(input rd_req_t r);
		req     = r;
		req_rdy = 1'b1;
		do begin
			@(posedge clk);
		end while (!req_ack);
		#2;
		req_rdy = 1'b0;
	endtask

	// Negative rot draws a random rotation per request
	task automatic send_batch(input int n, input int rot, input logic swz, input logic retire);
		swz_cfg_t  cfg;
		bank_idx_t c;
		for (int k = 0; k < n; k++) begin
			if (swz) begin
				cfg = rand_cfg(rot < 0 ? int'($urandom_range(LG_NBANK - 1)) : rot);
				c   = bank_idx_t'($urandom);
			end else begin
				cfg     = '0;
				cfg.rot = rot_t'(rot);
				c       = '0;
			end
			send_req(make_req(c, cfg, retire));
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// With the pool empty this request must never be taken
	task automatic expect_stall(input int cycles);
		logic seen;
		seen    = 1'b0;
		req     = make_req(bank_idx_t'($urandom), rand_cfg(0), 1'b1);
		req_rdy = 1'b1;
		repeat (cycles) begin
			@(posedge clk);
			if (req_ack) begin
				seen = 1'b1;
			end
			#2;
		end
		req_rdy = 1'b0;
		if (seen) begin
			log_error("request was accepted although every read tag was in use");
		end
	endtask

	task automatic build_ack_pattern();
		int   pos;
		int   len;
		logic lvl;
		pos = 0;
		while (pos < ACK_PAT_LEN) begin
			lvl = 1'($urandom_range(1));
			len = int'($urandom_range(8, 1));
			for (int k = 0; k < len && pos < ACK_PAT_LEN; k++) begin
				ack_pat[pos] = lvl;
				pos++;
			end
		end
	endtask

	task automatic start_test();
		err_mark = err_cnt;
		acc_mark = acc_cnt;
		rsp_mark = rsp_cnt;
	endtask

	task automatic finish_test(input int num, input string name);
		int n_acc;
		int n_rsp;
		n_acc = acc_cnt - acc_mark;
		n_rsp = rsp_cnt - rsp_mark;
		if (n_acc != n_rsp) begin
			log_error($sformatf("%0d requests accepted but %0d responses seen", n_acc, n_rsp));
		end
		if (err_cnt == err_mark) begin
			pass_cnt++;
			$display("test %0d %s: ok, %0d responses", num, name, n_rsp);
		end else begin
			fail_cnt++;
			$display("test %0d %s: FAIL, %0d errors", num, name, err_cnt - err_mark);
		end
	endtask

	//========================================
	// Response ack driver
	//========================================
	initial begin : ack_driver
		int mode;
		int pos;
		pos     = 0;
		rsp_ack = 1'b0;
		forever begin
			@(posedge clk);
			mode = ack_mode;
			#2;
			if (mode == ACK_PATTERN) begin
				rsp_ack = ack_pat[pos];
				pos     = (pos + 1) % ACK_PAT_LEN;
			end else begin
				rsp_ack = 1'b1;
			end
		end
	end

	//========================================
	// Scoreboard and comparator
	//========================================
	always @(posedge clk) begin : scoreboard
		rd_rsp_t          exp_rsp;
		logic [TAG_W-1:0] exp_tag;
		int               t;
		if (!rst) begin
			// A tag freed this cycle is only offered from the next cycle on
			if (req_rdy && req_ack) begin
				t = lowest_free(free_model);
				if (t < 0) begin
					log_error("request accepted while no read tag was free");
					t = 0;
				end
				free_model[t] = 1'b0;
				exp_q.push_back(ref_read(req));
				tag_q.push_back(TAG_W'(t));
				acc_cnt++;
			end else if (req_rdy && free_model == '0) begin
				tag_stall_cnt++;
			end
			if (held_valid && !rsp_rdy) begin
				log_error("response was withdrawn before it was acked");
			end else if (held_valid && (rsp != held_rsp || rsp_tag != held_tag)) begin
				log_mismatch("response changed while waiting for ack");
			end
			held_valid = 1'b0;
			if (rsp_rdy && rsp_ack) begin
				rsp_cnt++;
				if (exp_q.size() == 0) begin
					log_error("response arrived with no request outstanding");
				end else begin
					exp_rsp = exp_q.pop_front();
					exp_tag = tag_q.pop_front();
					for (int j = 0; j < NBANK; j++) begin
						if (rsp.data[j] != exp_rsp.data[j]) begin
							log_mismatch($sformatf("lane %0d read %h, expected %h",
								j, rsp.data[j], exp_rsp.data[j]));
						end
					end
					if (rsp.retire != exp_rsp.retire) begin
						log_mismatch($sformatf("retire %0b, expected %0b",
							rsp.retire, exp_rsp.retire));
					end
					if (rsp_tag != exp_tag) begin
						log_mismatch($sformatf("tag %0d, expected %0d", rsp_tag, exp_tag));
					end
					if (exp_rsp.retire) begin
						free_model[exp_tag] = 1'b1;
					end
				end
			end else if (rsp_rdy) begin
				held_rsp   = rsp;
				held_tag   = rsp_tag;
				held_valid = 1'b1;
			end
		end
	end

	//========================================
	// Watchdog
	//========================================
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

	//========================================
	// Test sequence
	//========================================
	initial begin : main
		int stall_mark;
		void'($urandom(SEED));
		req_rdy = 1'b0;
		req     = '0;
		wr_en   = 1'b0;
		wr_bank = '0;
		wr_row  = '0;
		wr_data = '0;
		build_ack_pattern();
		wait (!rst);
		@(posedge clk);
		#2;
		preload_all();

		// Mask zero lets each lane read its own bank
		start_test();
		send_batch(N_ID, 0, 1'b0, 1'b1);
		wait_drain();
		finish_test(1, "identity");

		start_test();
		send_batch(N_SWZ, 0, 1'b1, 1'b1);
		wait_drain();
		finish_test(2, "xor swizzle");

		start_test();
		for (int rot = 0; rot < LG_NBANK; rot++) begin
			send_batch(N_ROT_EACH, rot, 1'b1, 1'b1);
		end
		wait_drain();
		finish_test(3, "lane rotation");

		start_test();
		ack_mode = ACK_PATTERN;
		send_batch(N_BP, -1, 1'b1, 1'b1);
		wait_drain();
		ack_mode = ACK_HIGH;
		finish_test(4, "back-pressure");

		// Non-retire reads keep their tags and leave fewer for the rest
		start_test();
		stall_mark = tag_stall_cnt;
		send_batch(N_TAG / 2, 0, 1'b1, 1'b0);
		wait_drain();
		ack_mode = ACK_PATTERN;
		send_batch(N_TAG + 2, -1, 1'b1, 1'b1);
		wait_drain();
		ack_mode = ACK_HIGH;
		if (tag_stall_cnt == stall_mark) begin
			log_error("acceptance never stalled while the tag pool was empty");
		end
		send_batch(N_TAG - N_TAG / 2, 0, 1'b1, 1'b0);
		wait_drain();
		expect_stall(N_STALL_CYC);
		finish_test(5, "tag reuse");

		$display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
rtl/bank_geom_pkg.sv
rtl/bank_xfer_pkg.sv
rtl/rdyack_fwd.sv
rtl/read_tag_pool.sv
rtl/bank_sram_array.sv
rtl/bank_sram_read_if.sv
rtl/banked_read_top.sv
verification/tb_clk_gen.sv
verification/tb_banked_read.sv

//--- Bender.yml
package:
  name: banked_read

sources:
  # Packages first, geometry before transfer records
  - rtl/bank_geom_pkg.sv
  - rtl/bank_xfer_pkg.sv
  - rtl/rdyack_fwd.sv
  - rtl/read_tag_pool.sv
  - rtl/bank_sram_array.sv
  - rtl/bank_sram_read_if.sv
  - rtl/banked_read_top.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_banked_read.sv
